//--- include/i2f_assert.svh
/* Assertion macros. Clocked checks are disabled while reset is high and can be
   turned off as a group through the simulator's assertion control. */
`ifndef I2F_ASSERT_SVH
`define I2F_ASSERT_SVH

// Constant check evaluated once when simulation starts
`define ASSERT_INIT(__name, __prop, __desc) \
  initial begin : __name \
    assert (__prop) else $fatal(1, __desc); \
  end

// Property checked on every rising clock edge outside reset
`define ASSERT(__name, __prop, __clk, __rst, __desc) \
  __name : assert property (@(posedge __clk) disable iff (__rst) (__prop)) \
    else $error(__desc);

`endif

//--- logic/i2f_pkg.sv
/* Shared widths and register map of the integer to float peripheral.
   The core assumes a 32-bit operand and IEEE-754 single precision output. */
`default_nettype none

package i2f_pkg;

  // Operand and result width
  localparam int unsigned DataW = 32;
  // Width of a zero count over DataW bits
  localparam int unsigned CntW = 5;
  // Stored fraction and exponent field widths of single precision
  localparam int unsigned MantW = 23;
  localparam int unsigned ExpW = 8;
  localparam int unsigned ExpBias = 127;

  // APB address width covers the four word registers
  localparam int unsigned ApbAddrW = 4;

  // Register offsets
  localparam logic [ApbAddrW-1:0] RegOperand = 4'h0;
  localparam logic [ApbAddrW-1:0] RegCtrl = 4'h4;
  localparam logic [ApbAddrW-1:0] RegResult = 4'h8;
  localparam logic [ApbAddrW-1:0] RegStatus = 4'hC;

  // Control register field
  localparam int unsigned CtrlSignedBit = 0;

  // Status register field positions
  localparam int unsigned StatBusyBit = 0;
  localparam int unsigned StatLzLsb = 8;
  localparam int unsigned StatTzLsb = 16;
  localparam int unsigned StatZeroBit = 24;

endpackage

`default_nettype wire

//--- logic/lzc.sv
/* Leading or trailing zero counter. MODE 1 counts from the MSB, MODE 0 from the LSB.
   For an all-zero input empty_o is set and cnt_o holds WIDTH-1. */
`default_nettype none

`include "i2f_assert.svh"

module lzc #(
  parameter int unsigned WIDTH = 32,
  parameter bit          MODE  = 1'b0,
  // Derived from WIDTH and not meant to be overridden
  localparam int unsigned CntWidth = (WIDTH > 1) ? $clog2(WIDTH) : 1
) (
  input  logic [WIDTH-1:0]    in_i,
  output logic [CntWidth-1:0] cnt_o,
  output logic                empty_o
);

  `ASSERT_INIT(width_check, WIDTH >= 1, "lzc input must be at least one bit wide")

  if (WIDTH == 1) begin : gen_single

    // A single bit has only one possible count
    assign cnt_o   = '0;
    assign empty_o = ~in_i[0];

  end else begin : gen_tree

    // Tree depth and number of leaf positions after padding to a power of two
    localparam int unsigned Levels = CntWidth;
    localparam int unsigned Leaves = 2 ** Levels;

    // Input in search order with zero padding above WIDTH
    logic [Leaves-1:0] bits;
    // Heap ordered nodes, the children of node n sit at 2n+1 and 2n+2
    logic [Leaves-2:0]             sel_nodes;
    logic [Leaves-2:0][Levels-1:0] idx_nodes;

    // Leading-zero mode searches the reversed vector, so the lowest set
    // position in bits is the number of zeros above the first one
    always_comb begin
      bits = '0;
      for (int unsigned i = 0; i < WIDTH; i++) begin
        bits[i] = MODE ? in_i[WIDTH-1-i] : in_i[i];
      end
    end

    for (genvar lvl = 0; lvl < Levels; lvl++) begin : gen_level
      localparam int unsigned Base = 2 ** lvl - 1;

      for (genvar k = 0; k < 2 ** lvl; k++) begin : gen_node
        if (lvl == Levels - 1) begin : gen_leaf
          // Bottom level compares two neighbouring input bits
          assign sel_nodes[Base+k] = bits[2*k] | bits[2*k+1];
          assign idx_nodes[Base+k] = bits[2*k] ? Levels'(2 * k) : Levels'(2 * k + 1);
        end else begin : gen_inner
          localparam int unsigned Lo = 2 * (Base + k) + 1;

          // The lower half wins whenever it holds a set bit
          assign sel_nodes[Base+k] = sel_nodes[Lo] | sel_nodes[Lo+1];
          assign idx_nodes[Base+k] = sel_nodes[Lo] ? idx_nodes[Lo] : idx_nodes[Lo+1];
        end
      end
    end

    // The root carries the answer for the whole vector
    assign empty_o = ~sel_nodes[0];

    // Padding can steer the empty case to a lower index, so the count is forced
    assign cnt_o = empty_o ? CntWidth'(WIDTH - 1) : idx_nodes[0];

  end

endmodule

`default_nettype wire

//--- logic/norm_shift.sv
/* First conversion stage. Expects lz_i to be the exact leading-zero count of
   mag_i, and zero_i to mark a zero magnitude. */
`default_nettype none

`include "i2f_assert.svh"

module norm_shift import i2f_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             valid_i,
  input  logic             sign_i,
  input  logic [DataW-1:0] mag_i,
  input  logic [CntW-1:0]  lz_i,
  input  logic             zero_i,
  output logic             valid_o,
  output logic             sign_o,
  output logic [ExpW-1:0]  exp_o,
  output logic [DataW-1:0] norm_o,
  output logic             zero_o
);

  logic [DataW-1:0] shifted;
  logic [ExpW-1:0]  exp_d;

  // Move the leading one up to the MSB
  assign shifted = mag_i << lz_i;

  // The leading one at bit DataW-1-lz sets the unbiased exponent
  // Zero gets a cleared exponent, stage two packs it as +0 anyway
  assign exp_d = zero_i ? '0 : ExpW'(ExpBias + DataW - 1) - ExpW'(lz_i);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // Data only loads with a valid item
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      sign_o <= sign_i;
      exp_o  <= exp_d;
      norm_o <= shifted;
      zero_o <= zero_i;
    end
  end

  // The counter and the shifter must agree on where the leading one is
  `ASSERT(norm_msb_a, valid_i && !zero_i |-> shifted[DataW-1], clk_i, rst_i,
          "normalized magnitude lacks its leading one")

endmodule

`default_nettype wire

//--- logic/round_pack.sv
/* Second conversion stage. Round-to-nearest-even only, no other rounding modes.
   norm_i must have its MSB set unless zero_i is high. */
`default_nettype none

module round_pack import i2f_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             valid_i,
  input  logic             sign_i,
  input  logic [ExpW-1:0]  exp_i,
  input  logic [DataW-1:0] norm_i,
  input  logic             zero_i,
  output logic             valid_o,
  output logic [DataW-1:0] result_o
);

  logic [MantW-1:0] frac;
  logic             guard;
  logic             sticky;
  logic             round_up;
  logic [MantW:0]   frac_rnd;
  logic [ExpW-1:0]  exp_rnd;
  logic [DataW-1:0] packed_d;

  // The MSB is the hidden one, the next MantW bits are the stored fraction
  assign frac = norm_i[DataW-2 -: MantW];

  // First dropped bit
  assign guard = norm_i[DataW-MantW-2];

  // Any other dropped bit set means the value is above the halfway point
  assign sticky = |norm_i[DataW-MantW-3:0];

  // Ties go to the even fraction
  assign round_up = guard & (sticky | frac[0]);

  // One extra bit catches the fraction overflow
  assign frac_rnd = {1'b0, frac} + {{MantW{1'b0}}, round_up};

  // On overflow the value doubles, so the exponent steps up by one
  assign exp_rnd = exp_i + ExpW'(frac_rnd[MantW]);

  // After a carry-out the lower fraction bits are already all zero
  // A zero magnitude always packs as positive zero
  assign packed_d = zero_i ? '0 : {sign_i, exp_rnd, frac_rnd[MantW-1:0]};

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      result_o <= packed_d;
    end
  end

endmodule

`default_nettype wire

//--- logic/i2f_core.sv
/* Two-stage integer to float core. A start gives done two cycles later and it
   accepts a new start every cycle. There is no stall input. */
`default_nettype none

module i2f_core import i2f_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             start_i,
  input  logic [DataW-1:0] operand_i,
  input  logic             signed_i,
  output logic             done_o,
  output logic [DataW-1:0] result_o,
  output logic [CntW-1:0]  lz_o,
  output logic [CntW-1:0]  tz_o,
  output logic             zero_o
);

  logic             neg;
  logic [DataW-1:0] mag;
  logic [CntW-1:0]  lz;
  logic [CntW-1:0]  tz;
  logic             mag_zero;
  // Stage one outputs
  logic             s1_valid;
  logic             s1_sign;
  logic [ExpW-1:0]  s1_exp;
  logic [DataW-1:0] s1_norm;
  logic             s1_zero;
  // Counts carried along beside the stages
  logic [CntW-1:0]  lz_s1;
  logic [CntW-1:0]  tz_s1;
  logic [CntW-1:0]  lz_s2;
  logic [CntW-1:0]  tz_s2;
  logic             zero_s2;

  // Only a signed operand can be negative
  assign neg = signed_i & operand_i[DataW-1];

  // Negating 0x80000000 wraps back to itself, which is the right unsigned magnitude
  assign mag = neg ? -operand_i : operand_i;

  // Leading zeros give the shift and exponent, empty flags a zero magnitude
  lzc #(.WIDTH(DataW), .MODE(1'b1)) lzc_lead (
    .in_i   (mag),
    .cnt_o  (lz),
    .empty_o(mag_zero)
  );

  // Trailing zeros tell software how many low bits the float can drop
  lzc #(.WIDTH(DataW), .MODE(1'b0)) lzc_trail (
    .in_i   (mag),
    .cnt_o  (tz),
    .empty_o()
  );

  norm_shift stage1 (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .valid_i(start_i),
    .sign_i (neg),
    .mag_i  (mag),
    .lz_i   (lz),
    .zero_i (mag_zero),
    .valid_o(s1_valid),
    .sign_o (s1_sign),
    .exp_o  (s1_exp),
    .norm_o (s1_norm),
    .zero_o (s1_zero)
  );

  round_pack stage2 (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (s1_valid),
    .sign_i  (s1_sign),
    .exp_i   (s1_exp),
    .norm_i  (s1_norm),
    .zero_i  (s1_zero),
    .valid_o (done_o),
    .result_o(result_o)
  );

  // Counts and zero flag follow the item so status lines up with the result
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      lz_s1 <= lz;
      tz_s1 <= tz;
    end
    if (s1_valid) begin
      lz_s2   <= lz_s1;
      tz_s2   <= tz_s1;
      zero_s2 <= s1_zero;
    end
  end

  assign lz_o   = lz_s2;
  assign tz_o   = tz_s2;
  assign zero_o = zero_s2;

endmodule

`default_nettype wire

//--- logic/apb_i2f_regs.sv
/* APB3 register block. Writes never wait; result and status reads wait while a
   conversion is in flight. Unmapped offsets and writes to read-only registers error. */
`default_nettype none

`include "i2f_assert.svh"

module apb_i2f_regs import i2f_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic [ApbAddrW-1:0] paddr_i,
  input  logic                psel_i,
  input  logic                penable_i,
  input  logic                pwrite_i,
  input  logic [DataW-1:0]    pwdata_i,
  output logic [DataW-1:0]    prdata_o,
  output logic                pready_o,
  output logic                pslverr_o,
  output logic                start_o,
  output logic [DataW-1:0]    operand_o,
  output logic                signed_o,
  input  logic                done_i,
  input  logic [DataW-1:0]    result_i,
  input  logic [CntW-1:0]     lz_i,
  input  logic [CntW-1:0]     tz_i,
  input  logic                zero_i
);

  logic             access;
  logic             hit_operand;
  logic             hit_ctrl;
  logic             hit_result;
  logic             hit_status;
  logic             rd_wait;
  logic             err;
  logic             wr_done;
  logic             busy;
  logic [1:0]       pending_q;
  logic [DataW-1:0] result_q;
  logic [CntW-1:0]  lz_q;
  logic [CntW-1:0]  tz_q;
  logic             zero_q;
  logic [DataW-1:0] status;

  assign access      = psel_i & penable_i;
  assign hit_operand = paddr_i == RegOperand;
  assign hit_ctrl    = paddr_i == RegCtrl;
  assign hit_result  = paddr_i == RegResult;
  assign hit_status  = paddr_i == RegStatus;

  // Back-pressure applies to result and status reads only
  assign rd_wait  = ~pwrite_i & busy & (hit_result | hit_status);
  assign pready_o = access & ~rd_wait;

  // Writes may only target operand and control, reads any mapped offset
  assign err = pwrite_i ? ~(hit_operand | hit_ctrl)
                        : ~(hit_operand | hit_ctrl | hit_result | hit_status);
  assign pslverr_o = pready_o & err;
  assign wr_done   = pready_o & pwrite_i & ~err;

  // Conversions in flight, busy as long as any is outstanding
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_q <= '0;
    end else begin
      pending_q <= pending_q + 2'(wr_done & hit_operand) - 2'(done_i);
    end
  end
  assign busy = pending_q != '0;

  // Start fires the cycle after the write, when the operand register is stable
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      start_o  <= 1'b0;
      signed_o <= 1'b0;
    end else begin
      start_o <= wr_done & hit_operand;
      if (wr_done && hit_ctrl) begin
        signed_o <= pwdata_i[CtrlSignedBit];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_done && hit_operand) begin
      operand_o <= pwdata_i;
    end
  end

  // Result and counts are captured together so status describes the result
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      result_q <= '0;
      lz_q     <= '0;
      tz_q     <= '0;
      zero_q   <= 1'b0;
    end else if (done_i) begin
      result_q <= result_i;
      lz_q     <= lz_i;
      tz_q     <= tz_i;
      zero_q   <= zero_i;
    end
  end

  always_comb begin
    status = '0;
    status[StatBusyBit] = busy;
    status[StatLzLsb +: CntW] = lz_q;
    status[StatTzLsb +: CntW] = tz_q;
    status[StatZeroBit] = zero_q;
  end

  // Read data is driven only during a read access, operand reads back as zero
  always_comb begin
    prdata_o = '0;
    if (access && !pwrite_i) begin
      if (hit_ctrl) begin
        prdata_o[CtrlSignedBit] = signed_o;
      end else if (hit_result) begin
        prdata_o = result_q;
      end else if (hit_status) begin
        prdata_o = status;
      end
    end
  end

  // The core only finishes work that this block started
  `ASSERT(done_busy_a, done_i |-> busy, clk_i, rst_i, "core done without a pending conversion")

endmodule

`default_nettype wire

//--- logic/i2f_top.sv
/* APB integer to float peripheral. Allows one conversion in flight at a time
   and rounds to nearest even only. */
`default_nettype none

module i2f_top import i2f_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic [ApbAddrW-1:0] paddr_i,
  input  logic                psel_i,
  input  logic                penable_i,
  input  logic                pwrite_i,
  input  logic [DataW-1:0]    pwdata_i,
  output logic [DataW-1:0]    prdata_o,
  output logic                pready_o,
  output logic                pslverr_o
);

  // Register block to core
  logic             start;
  logic [DataW-1:0] operand;
  logic             signed_mode;
  // Core back to the register block
  logic             done;
  logic [DataW-1:0] result;
  logic [CntW-1:0]  lz;
  logic [CntW-1:0]  tz;
  logic             zero;

  apb_i2f_regs regs0 (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .paddr_i  (paddr_i),
    .psel_i   (psel_i),
    .penable_i(penable_i),
    .pwrite_i (pwrite_i),
    .pwdata_i (pwdata_i),
    .prdata_o (prdata_o),
    .pready_o (pready_o),
    .pslverr_o(pslverr_o),
    .start_o  (start),
    .operand_o(operand),
    .signed_o (signed_mode),
    .done_i   (done),
    .result_i (result),
    .lz_i     (lz),
    .tz_i     (tz),
    .zero_i   (zero)
  );

  i2f_core core0 (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .start_i  (start),
    .operand_i(operand),
    .signed_i (signed_mode),
    .done_o   (done),
    .result_o (result),
    .lz_o     (lz),
    .tz_o     (tz),
    .zero_o   (zero)
  );

endmodule

`default_nettype wire

//--- dv/i2f_tb.sv
/* Testbench for the APB integer to float peripheral. Expected floats and status come
   from a bit-level model of the conversion rule. Stops at the first mismatch. */
`default_nettype none

module i2f_tb import i2f_pkg::*; ();

  localparam int          NumTab      = 18;
  localparam int          NumRand     = 200;
  localparam int          ResetCycles = 10;
  // A vector takes about 14 cycles and the error checks count as three more vectors
  localparam int          CycleLimit  = (NumTab + NumRand + 3) * 20 + ResetCycles;
  localparam logic [31:0] Seed        = 32'h5297d0ec;

  logic                clk;
  logic                rst;
  logic [ApbAddrW-1:0] paddr;
  logic                psel;
  logic                penable;
  logic                pwrite;
  logic [DataW-1:0]    pwdata;
  logic [DataW-1:0]    prdata;
  logic                pready;
  logic                pslverr;

  // Entries are {signed mode, operand, hand-computed float}
  logic [64:0]         vec_table [NumTab];
  logic [31:0]         last_result;
  int                  cycles;

  i2f_top dut0 (
    .clk_i    (clk),
    .rst_i    (rst),
    .paddr_i  (paddr),
    .psel_i   (psel),
    .penable_i(penable),
    .pwrite_i (pwrite),
    .pwdata_i (pwdata),
    .prdata_o (prdata),
    .pready_o (pready),
    .pslverr_o(pslverr)
  );

  always #2 clk = ~clk;

  task automatic report_failure();
    $display("TESTBENCH FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAIL %s got 0x%08h expected 0x%08h", name, got, exp);
      report_failure();
    end
  endtask

  // Guards against a DUT that never raises pready
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CycleLimit) begin
      $display("Timeout: the run took more than %0d cycles", CycleLimit);
      report_failure();
    end
  end

  function automatic logic [31:0] magnitude(input logic [31:0] op, input logic sgn);
    // Two's complement negation maps 0x80000000 onto itself
    return (sgn && op[31]) ? (~op + 32'd1) : op;
  endfunction

  function automatic int count_lead(input logic [31:0] v);
    int n;
    bit found;
    n = 0;
    found = 1'b0;
    for (int i = 31; i >= 0; i--) begin
      if (v[i]) begin
        found = 1'b1;
      end else if (!found) begin
        n++;
      end
    end
    // An all-zero word reports 31 in both counts
    return found ? n : 31;
  endfunction

  function automatic int count_trail(input logic [31:0] v);
    int n;
    bit found;
    n = 0;
    found = 1'b0;
    for (int i = 0; i < 32; i++) begin
      if (v[i]) begin
        found = 1'b1;
      end else if (!found) begin
        n++;
      end
    end
    return found ? n : 31;
  endfunction

  function automatic logic [31:0] model_float(input logic [31:0] op, input logic sgn);
    logic        neg;
    logic [31:0] m;
    logic [31:0] norm;
    int          lead;
    logic [7:0]  expo;
    logic [23:0] frac_r;
    logic        guard;
    logic        sticky;
    neg = sgn && op[31];
    m = magnitude(op, sgn);
    if (m == 32'h0) begin
      return 32'h0;
    end
    lead = count_lead(m);
    norm = m << lead;
    expo = 8'(127 + 31 - lead);
    frac_r = {1'b0, norm[30:8]};
    guard = norm[7];
    sticky = |norm[6:0];
    // Round to nearest and keep an even fraction on a tie
    if (guard && (sticky || norm[8])) begin
      frac_r = frac_r + 24'd1;
    end
    if (frac_r[23]) begin
      expo = expo + 8'd1;
    end
    return {neg, expo, frac_r[22:0]};
  endfunction

  function automatic logic [31:0] model_status(input logic [31:0] op, input logic sgn);
    logic [31:0] m;
    logic [4:0]  lz;
    logic [4:0]  tz;
    m = magnitude(op, sgn);
    lz = 5'(count_lead(m));
    tz = 5'(count_trail(m));
    // Busy reads low once the result is available
    return {7'b0, m == 32'h0, 3'b0, tz, 3'b0, lz, 7'b0, 1'b0};
  endfunction

  // One APB3 transfer sampled at the falling edge where pready is settled
  task automatic apb_access(input logic write, input logic [3:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic slverr, output int waits);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    waits = 0;
    @(negedge clk);
    while (!pready) begin
      waits++;
      @(negedge clk);
    end
    rdata = prdata;
    slverr = pslverr;
    // The transfer completes on this edge
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic run_vector(input logic [31:0] op, input logic sgn);
    logic [31:0] rdata;
    logic        err;
    int          waits;
    logic [31:0] exp_f;
    exp_f = model_float(op, sgn);
    apb_access(1'b1, RegCtrl, {31'b0, sgn}, rdata, err, waits);
    check_value("pslverr_o", 32'(err), 32'h0);
    apb_access(1'b1, RegOperand, op, rdata, err, waits);
    check_value("pslverr_o", 32'(err), 32'h0);
    assert (waits == 0) else begin
      $display("The operand write was stretched by wait states");
      report_failure();
    end
    // Issued while the conversion is still in flight
    apb_access(1'b0, RegResult, 32'h0, rdata, err, waits);
    assert (waits > 0) else begin
      $display("The result read did not wait for the busy conversion");
      report_failure();
    end
    check_value("prdata_o", rdata, exp_f);
    apb_access(1'b0, RegStatus, 32'h0, rdata, err, waits);
    check_value("prdata_o", rdata, model_status(op, sgn));
    last_result = exp_f;
  endtask

  task automatic load_table();
    vec_table[0]  = {1'b0, 32'h00000001, 32'h3F800000};
    vec_table[1]  = {1'b0, 32'h00000002, 32'h40000000};
    vec_table[2]  = {1'b0, 32'h00000100, 32'h43800000};
    vec_table[3]  = {1'b0, 32'h40000000, 32'h4E800000};
    vec_table[4]  = {1'b0, 32'h00FFFFFF, 32'h4B7FFFFF};
    vec_table[5]  = {1'b0, 32'h01000001, 32'h4B800000};
    vec_table[6]  = {1'b0, 32'h01000003, 32'h4B800002};
    vec_table[7]  = {1'b0, 32'h02000002, 32'h4C000000};
    vec_table[8]  = {1'b0, 32'h02000003, 32'h4C000001};
    vec_table[9]  = {1'b0, 32'hFFFFFFFF, 32'h4F800000};
    vec_table[10] = {1'b0, 32'h7FFFFFFF, 32'h4F000000};
    vec_table[11] = {1'b0, 32'h80000000, 32'h4F000000};
    vec_table[12] = {1'b1, 32'h80000000, 32'hCF000000};
    vec_table[13] = {1'b1, 32'hFFFFFFFF, 32'hBF800000};
    vec_table[14] = {1'b1, 32'hFFFFFFFB, 32'hC0A00000};
    vec_table[15] = {1'b1, 32'h00000007, 32'h40E00000};
    vec_table[16] = {1'b0, 32'h00000000, 32'h00000000};
    vec_table[17] = {1'b1, 32'h00000000, 32'h00000000};
  endtask

  initial begin
    logic [31:0] rdata;
    logic        err;
    int          waits;
    logic [31:0] op;
    logic        sgn;
    clk = 1'b0;
    rst = 1'b1;
    paddr = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    pwdata = '0;
    cycles = 0;
    last_result = 32'h0;
    void'($urandom(Seed));
    load_table();
    repeat (ResetCycles) @(posedge clk);
    rst <= 1'b0;

    // Result and status read zero out of reset
    apb_access(1'b0, RegResult, 32'h0, rdata, err, waits);
    check_value("prdata_o", rdata, 32'h0);
    apb_access(1'b0, RegStatus, 32'h0, rdata, err, waits);
    check_value("prdata_o", rdata, 32'h0);

    for (int i = 0; i < NumTab; i++) begin
      // The model has to agree with the hand-computed value first
      check_value("expected float", model_float(vec_table[i][63:32], vec_table[i][64]),
                  vec_table[i][31:0]);
      run_vector(vec_table[i][63:32], vec_table[i][64]);
    end

    for (int i = 0; i < NumRand; i++) begin
      op = $urandom();
      sgn = 1'($urandom());
      run_vector(op, sgn);
    end

    // Write to a read-only register and accesses to unmapped offsets
    apb_access(1'b1, RegResult, 32'h12345678, rdata, err, waits);
    check_value("pslverr_o", 32'(err), 32'h1);
    apb_access(1'b0, 4'h2, 32'h0, rdata, err, waits);
    check_value("pslverr_o", 32'(err), 32'h1);
    apb_access(1'b1, 4'h6, 32'h00000055, rdata, err, waits);
    check_value("pslverr_o", 32'(err), 32'h1);
    apb_access(1'b0, RegResult, 32'h0, rdata, err, waits);
    check_value("pslverr_o", 32'(err), 32'h0);
    check_value("prdata_o", rdata, last_result);
    apb_access(1'b0, RegStatus, 32'h0, rdata, err, waits);
    check_value("prdata_o busy", 32'(rdata[0]), 32'h0);

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+include
logic/i2f_pkg.sv
logic/lzc.sv
logic/norm_shift.sv
logic/round_pack.sv
logic/i2f_core.sv
logic/apb_i2f_regs.sv
logic/i2f_top.sv
dv/i2f_tb.sv
